//--- verilog/rename_pkg.sv
package rename_pkg;

    // ========================================
    // Rename geometry
    // ========================================

    // Lanes renamed per cycle
    localparam int RENAME_WIDTH = 3;

    // Architectural file and reorder buffer sizes
    localparam int ARCH_REGS = 32;
    localparam int ROB_DEPTH = 32;

    localparam int ARCH_ADDR_W = 5;
    localparam int ROB_IDX_W   = 5;

    // Free count spans 0 to ROB_DEPTH inclusive
    localparam int COUNT_W = 6;

    typedef logic [ARCH_ADDR_W-1:0] arch_addr_t;
    typedef logic [ROB_IDX_W-1:0]   rob_idx_t;

    // ========================================
    // Physical tag, flag on the top bit
    // ========================================

    // Flag clear: value lives in the register file
    // Flag set: value pending in a reorder-buffer slot
    typedef union packed {
        struct packed {
            logic       in_rob;
            arch_addr_t idx;
        } rf;
        struct packed {
            logic     in_rob;
            rob_idx_t idx;
        } rob;
    } phys_tag_u;

    // Register file view of an architectural register
    function automatic phys_tag_u rf_view(arch_addr_t addr);
        phys_tag_u tag;
        tag.rf.in_rob = 1'b0;
        tag.rf.idx    = addr;
        return tag;
    endfunction

    // Reorder buffer view of a slot index
    function automatic phys_tag_u rob_view(rob_idx_t idx);
        phys_tag_u tag;
        tag.rob.in_rob = 1'b1;
        tag.rob.idx    = idx;
        return tag;
    endfunction

endpackage

//--- verilog/rob_tag_free_list.sv
`timescale 1ns/1ps

module rob_tag_free_list import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush_i,
    input  logic [RENAME_WIDTH-1:0] decode_valid_i,
    input  logic [RENAME_WIDTH-1:0] commit_valid_i,
    output logic [RENAME_WIDTH-1:0] grant_o,
    output rob_idx_t                grant_tag_o [RENAME_WIDTH],
    output logic [RENAME_WIDTH-1:0] rename_ready_o
);

    // Next slot to hand out
    rob_idx_t           head_q;
    // Slots not yet handed out
    logic [COUNT_W-1:0] free_count_q;

    logic [COUNT_W-1:0] grant_cnt;
    logic [COUNT_W-1:0] commit_cnt;
    rob_idx_t           tag_walk;

    // ========================================
    // Ready thermometer and grants
    // ========================================

    always_comb begin
        // Lane n ready when more than n slots remain
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            rename_ready_o[n] = (free_count_q > COUNT_W'(n));
        end
        // Nothing accepted while reset is held
        grant_o = decode_valid_i & rename_ready_o & {RENAME_WIDTH{reset}};
    end

    // Consecutive tags for accepted lanes
    // Idle lanes do not advance the walk
    always_comb begin
        tag_walk  = head_q;
        grant_cnt = '0;
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            grant_tag_o[n] = tag_walk;
            if (grant_o[n]) begin
                // Wraps modulo ROB_DEPTH through the index width
                tag_walk  = tag_walk + 1'b1;
                grant_cnt = grant_cnt + 1'b1;
            end
        end
    end

    // Slots handed back by the reorder buffer this cycle
    always_comb begin
        commit_cnt = '0;
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            commit_cnt = commit_cnt + COUNT_W'(commit_valid_i[n]);
        end
    end

    // ========================================
    // Head pointer and free count
    // ========================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_q       <= '0;
            free_count_q <= COUNT_W'(ROB_DEPTH);
        end else begin
            // Head keeps moving through a flush
            head_q <= head_q + grant_cnt[ROB_IDX_W-1:0];
            if (flush_i) begin
                // Flush only refills the count
                free_count_q <= COUNT_W'(ROB_DEPTH);
            end else begin
                // Committed slots show up one cycle later
                free_count_q <= free_count_q - grant_cnt + commit_cnt;
            end
        end
    end

endmodule

//--- verilog/map_table.sv
`timescale 1ns/1ps

module map_table import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush_i,
    // Decode lanes
    input  arch_addr_t              rs1_arch_i [RENAME_WIDTH],
    input  arch_addr_t              rs2_arch_i [RENAME_WIDTH],
    input  arch_addr_t              rd_arch_i [RENAME_WIDTH],
    // Retirement from the reorder buffer
    input  logic [RENAME_WIDTH-1:0] commit_valid_i,
    input  arch_addr_t              commit_arch_i [RENAME_WIDTH],
    input  rob_idx_t                commit_rob_idx_i [RENAME_WIDTH],
    // Rename writes from the merge
    input  logic [RENAME_WIDTH-1:0] wr_en_i,
    input  phys_tag_u               wr_tag_i [RENAME_WIDTH],
    // Current mappings
    output phys_tag_u               rs1_map_o [RENAME_WIDTH],
    output phys_tag_u               rs2_map_o [RENAME_WIDTH],
    output phys_tag_u               rd_map_o [RENAME_WIDTH]
);

    // Architectural to physical map
    phys_tag_u table_q [ARCH_REGS];
    phys_tag_u table_d [ARCH_REGS];

    // ========================================
    // Reads
    // ========================================

    // Straight from the registered table, bypass happens in the merge
    always_comb begin
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            rs1_map_o[n] = table_q[rs1_arch_i[n]];
            rs2_map_o[n] = table_q[rs2_arch_i[n]];
            rd_map_o[n]  = table_q[rd_arch_i[n]];
        end
    end

    // ========================================
    // Next table
    // ========================================

    always_comb begin
        table_d = table_q;

        // Commits first, oldest lane first
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            // Release only if nothing renamed the register since
            if (commit_valid_i[n] && commit_arch_i[n] != '0 &&
                table_d[commit_arch_i[n]] == rob_view(commit_rob_idx_i[n])) begin
                table_d[commit_arch_i[n]] = rf_view(commit_arch_i[n]);
            end
        end

        // Rename writes on top, youngest lane wins
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            // x0 stays hardwired to the file
            if (wr_en_i[n] && rd_arch_i[n] != '0) begin
                table_d[rd_arch_i[n]] = wr_tag_i[n];
            end
        end
    end

    // ========================================
    // Table register
    // ========================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity map, everything in the file
            for (int i = 0; i < ARCH_REGS; i++) begin
                table_q[i] <= rf_view(arch_addr_t'(i));
            end
        end else if (flush_i) begin
            // Flush overrides commits and renames
            for (int i = 0; i < ARCH_REGS; i++) begin
                table_q[i] <= rf_view(arch_addr_t'(i));
            end
        end else begin
            table_q <= table_d;
        end
    end

endmodule

//--- verilog/rename_merge.sv
`timescale 1ns/1ps

module rename_merge import rename_pkg::*; (
    input  arch_addr_t              rs1_arch_i [RENAME_WIDTH],
    input  arch_addr_t              rs2_arch_i [RENAME_WIDTH],
    input  arch_addr_t              rd_arch_i [RENAME_WIDTH],
    input  logic [RENAME_WIDTH-1:0] rd_we_i,
    // From the free list
    input  logic [RENAME_WIDTH-1:0] grant_i,
    input  rob_idx_t                grant_tag_i [RENAME_WIDTH],
    // From the map table
    input  phys_tag_u               rs1_map_i [RENAME_WIDTH],
    input  phys_tag_u               rs2_map_i [RENAME_WIDTH],
    input  phys_tag_u               rd_map_i [RENAME_WIDTH],
    // Rename results
    output phys_tag_u               rs1_phys_o [RENAME_WIDTH],
    output phys_tag_u               rs2_phys_o [RENAME_WIDTH],
    output phys_tag_u               rd_phys_o [RENAME_WIDTH],
    output phys_tag_u               old_rd_phys_o [RENAME_WIDTH],
    output logic [RENAME_WIDTH-1:0] rename_valid_o,
    // Map table writes
    output logic [RENAME_WIDTH-1:0] wr_en_o,
    output phys_tag_u               wr_tag_o [RENAME_WIDTH]
);

    phys_tag_u               lane_tag [RENAME_WIDTH];
    // Lane really remaps its destination
    logic [RENAME_WIDTH-1:0] lane_writes;

    // Youngest older writer of src wins, else the table read
    function automatic phys_tag_u bypass(arch_addr_t src, phys_tag_u table_val, int lane);
        phys_tag_u result;
        result = table_val;
        for (int m = 0; m < RENAME_WIDTH; m++) begin
            if (m < lane && lane_writes[m] && rd_arch_i[m] == src) begin
                result = lane_tag[m];
            end
        end
        return result;
    endfunction

    // ========================================
    // Lane tags and write requests
    // ========================================

    always_comb begin
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            lane_tag[n]    = rob_view(grant_tag_i[n]);
            // x0 never remapped, so never a bypass source either
            lane_writes[n] = grant_i[n] && rd_we_i[n] && rd_arch_i[n] != '0;
            wr_tag_o[n]    = lane_tag[n];
        end
        wr_en_o        = lane_writes;
        rename_valid_o = grant_i;
    end

    // In-group bypass for sources and previous destination
    always_comb begin
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            if (grant_i[n]) begin
                rs1_phys_o[n]    = bypass(rs1_arch_i[n], rs1_map_i[n], n);
                rs2_phys_o[n]    = bypass(rs2_arch_i[n], rs2_map_i[n], n);
                old_rd_phys_o[n] = bypass(rd_arch_i[n], rd_map_i[n], n);
                rd_phys_o[n]     = lane_tag[n];
            end else begin
                rs1_phys_o[n]    = '0;
                rs2_phys_o[n]    = '0;
                old_rd_phys_o[n] = '0;
                rd_phys_o[n]     = '0;
            end
        end
    end

endmodule

//--- verilog/register_rename.sv
`timescale 1ns/1ps

module register_rename import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush_i,
    // Decode side
    input  logic [RENAME_WIDTH-1:0] decode_valid_i,
    input  arch_addr_t              rs1_arch_i [RENAME_WIDTH],
    input  arch_addr_t              rs2_arch_i [RENAME_WIDTH],
    input  arch_addr_t              rd_arch_i [RENAME_WIDTH],
    input  logic [RENAME_WIDTH-1:0] rd_we_i,
    // Retirement side
    input  logic [RENAME_WIDTH-1:0] commit_valid_i,
    input  arch_addr_t              commit_arch_i [RENAME_WIDTH],
    input  rob_idx_t                commit_rob_idx_i [RENAME_WIDTH],
    // Rename results
    output phys_tag_u               rs1_phys_o [RENAME_WIDTH],
    output phys_tag_u               rs2_phys_o [RENAME_WIDTH],
    output phys_tag_u               rd_phys_o [RENAME_WIDTH],
    output phys_tag_u               old_rd_phys_o [RENAME_WIDTH],
    output logic [RENAME_WIDTH-1:0] rename_valid_o,
    output logic [RENAME_WIDTH-1:0] rename_ready_o
);

    // Free list to merge
    logic [RENAME_WIDTH-1:0] grant;
    rob_idx_t                grant_tag [RENAME_WIDTH];

    // Map table reads
    phys_tag_u               rs1_map [RENAME_WIDTH];
    phys_tag_u               rs2_map [RENAME_WIDTH];
    phys_tag_u               rd_map [RENAME_WIDTH];

    // Merge back to the map table
    logic [RENAME_WIDTH-1:0] wr_en;
    phys_tag_u               wr_tag [RENAME_WIDTH];

    rob_tag_free_list u_free_list (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .decode_valid_i (decode_valid_i),
        .commit_valid_i (commit_valid_i),
        .grant_o        (grant),
        .grant_tag_o    (grant_tag),
        .rename_ready_o (rename_ready_o)
    );

    map_table u_map_table (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .rs1_arch_i       (rs1_arch_i),
        .rs2_arch_i       (rs2_arch_i),
        .rd_arch_i        (rd_arch_i),
        .commit_valid_i   (commit_valid_i),
        .commit_arch_i    (commit_arch_i),
        .commit_rob_idx_i (commit_rob_idx_i),
        .wr_en_i          (wr_en),
        .wr_tag_i         (wr_tag),
        .rs1_map_o        (rs1_map),
        .rs2_map_o        (rs2_map),
        .rd_map_o         (rd_map)
    );

    rename_merge u_merge (
        .rs1_arch_i     (rs1_arch_i),
        .rs2_arch_i     (rs2_arch_i),
        .rd_arch_i      (rd_arch_i),
        .rd_we_i        (rd_we_i),
        .grant_i        (grant),
        .grant_tag_i    (grant_tag),
        .rs1_map_i      (rs1_map),
        .rs2_map_i      (rs2_map),
        .rd_map_i       (rd_map),
        .rs1_phys_o     (rs1_phys_o),
        .rs2_phys_o     (rs2_phys_o),
        .rd_phys_o      (rd_phys_o),
        .old_rd_phys_o  (old_rd_phys_o),
        .rename_valid_o (rename_valid_o),
        .wr_en_o        (wr_en),
        .wr_tag_o       (wr_tag)
    );

endmodule

//--- test/rename_clock_gen.sv
`timescale 1ns/1ps

module rename_clock_gen (
    output logic clk,
    output logic reset
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for 16 rising edges, released just after an edge
    initial begin
        reset = 1'b0;
        repeat (16) @(posedge clk);
        #1 reset = 1'b1;
    end

endmodule

//--- test/register_rename_tb.sv
`timescale 1ns/1ps

module register_rename_tb import rename_pkg::*; ();

    // Cycle budget per test including wait loops
    localparam int RESET_CYCLES = 16;
    localparam int LEN_RESET    = 6;
    localparam int LEN_TAGS     = 40;
    localparam int LEN_BYPASS   = 30;
    localparam int LEN_COMMIT   = 30;
    localparam int LEN_EXHAUST  = 30;
    localparam int LEN_FLUSH    = 21;
    localparam int CYCLE_LIMIT  = 2 * (LEN_RESET + LEN_TAGS + LEN_BYPASS + LEN_COMMIT
                                       + LEN_EXHAUST + LEN_FLUSH) + RESET_CYCLES;

    logic                    clk;
    logic                    reset;
    logic                    flush_i;
    logic [RENAME_WIDTH-1:0] decode_valid;
    logic [RENAME_WIDTH-1:0] rd_we;
    logic [RENAME_WIDTH-1:0] commit_valid;
    arch_addr_t              rs1_arch [RENAME_WIDTH];
    arch_addr_t              rs2_arch [RENAME_WIDTH];
    arch_addr_t              rd_arch [RENAME_WIDTH];
    arch_addr_t              commit_arch [RENAME_WIDTH];
    rob_idx_t                commit_rob_idx [RENAME_WIDTH];
    phys_tag_u               rs1_phys [RENAME_WIDTH];
    phys_tag_u               rs2_phys [RENAME_WIDTH];
    phys_tag_u               rd_phys [RENAME_WIDTH];
    phys_tag_u               old_rd_phys [RENAME_WIDTH];
    logic [RENAME_WIDTH-1:0] rename_valid_o;
    logic [RENAME_WIDTH-1:0] rename_ready_o;

    // ========================================
    // Reference model state and expectations
    // ========================================

    logic [5:0]              model_map [ARCH_REGS];
    rob_idx_t                model_head;
    int                      model_count;
    // Outstanding slots with the oldest first
    arch_addr_t              pend_arch [$];
    rob_idx_t                pend_idx [$];

    logic [RENAME_WIDTH-1:0] exp_ready;
    logic [RENAME_WIDTH-1:0] exp_valid;
    rob_idx_t                exp_tag [RENAME_WIDTH];
    logic [5:0]              exp_rs1 [RENAME_WIDTH];
    logic [5:0]              exp_rs2 [RENAME_WIDTH];
    logic [5:0]              exp_rd [RENAME_WIDTH];
    logic [5:0]              exp_old_rd [RENAME_WIDTH];

    string                   test_name;
    int                      checks = 0;
    int                      errors = 0;
    int                      test_check_base;
    int                      test_err_base;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      cycles = 0;
    logic [15:0]             lfsr_state = 16'd58672;

    rename_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    register_rename UUT (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .decode_valid_i   (decode_valid),
        .rs1_arch_i       (rs1_arch),
        .rs2_arch_i       (rs2_arch),
        .rd_arch_i        (rd_arch),
        .rd_we_i          (rd_we),
        .commit_valid_i   (commit_valid),
        .commit_arch_i    (commit_arch),
        .commit_rob_idx_i (commit_rob_idx),
        .rs1_phys_o       (rs1_phys),
        .rs2_phys_o       (rs2_phys),
        .rd_phys_o        (rd_phys),
        .old_rd_phys_o    (old_rd_phys),
        .rename_valid_o   (rename_valid_o),
        .rename_ready_o   (rename_ready_o)
    );

    // 16 bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [4:0] rand_bits(int count);
        logic [4:0] val;
        val = '0;
        for (int i = 0; i < count; i++) begin
            val = {val[3:0], lfsr_bit()};
        end
        return val;
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_map[i] = {1'b0, arch_addr_t'(i)};
        end
        model_head  = '0;
        model_count = ROB_DEPTH;
        pend_arch.delete();
        pend_idx.delete();
    endfunction

    // Youngest older lane of the group writing a non-zero src wins over the map
    function automatic logic [5:0] lookup(arch_addr_t src, int lane);
        for (int m = lane - 1; m >= 0; m--) begin
            if (exp_valid[m] && rd_we[m] && src != '0 && rd_arch[m] == src) begin
                return {1'b1, exp_tag[m]};
            end
        end
        return model_map[src];
    endfunction

    // Expected outputs of this cycle and the state after the next edge
    function automatic void reference_cycle();
        rob_idx_t walk;
        walk = model_head;
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            exp_ready[n]  = model_count > n;
            exp_valid[n]  = decode_valid[n] && exp_ready[n];
            exp_tag[n]    = walk;
            exp_rs1[n]    = '0;
            exp_rs2[n]    = '0;
            exp_rd[n]     = '0;
            exp_old_rd[n] = '0;
            if (exp_valid[n]) begin
                exp_rs1[n]    = lookup(rs1_arch[n], n);
                exp_rs2[n]    = lookup(rs2_arch[n], n);
                exp_old_rd[n] = lookup(rd_arch[n], n);
                exp_rd[n]     = {1'b1, walk};
                walk          = walk + 5'd1;
            end
        end
        if (flush_i) begin
            reset_model();
        end else begin
            // Retire oldest slots and release only an unchanged mapping
            for (int n = 0; n < RENAME_WIDTH; n++) begin
                if (commit_valid[n]) begin
                    if (commit_arch[n] != '0 &&
                        model_map[commit_arch[n]] == {1'b1, commit_rob_idx[n]}) begin
                        model_map[commit_arch[n]] = {1'b0, commit_arch[n]};
                    end
                    model_count++;
                    void'(pend_arch.pop_front());
                    void'(pend_idx.pop_front());
                end
            end
            for (int n = 0; n < RENAME_WIDTH; n++) begin
                if (exp_valid[n]) begin
                    if (rd_we[n] && rd_arch[n] != '0) begin
                        model_map[rd_arch[n]] = exp_rd[n];
                    end
                    model_count--;
                    pend_arch.push_back(rd_we[n] ? rd_arch[n] : arch_addr_t'(0));
                    pend_idx.push_back(exp_tag[n]);
                end
            end
        end
        // Head moves on grants even in a flush cycle
        model_head = walk;
    endfunction

    // ========================================
    // Checking and reporting
    // ========================================

    task automatic check_field(string what, logic [5:0] expected, logic [5:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Outputs settle 1 ns after the edge and are sampled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            reset_model();
        end else begin
            reference_cycle();
            check_field("ready", 6'(exp_ready), 6'(rename_ready_o));
            check_field("valid", 6'(exp_valid), 6'(rename_valid_o));
            for (int n = 0; n < RENAME_WIDTH; n++) begin
                check_field($sformatf("rs1 lane %0d", n), exp_rs1[n], rs1_phys[n]);
                check_field($sformatf("rs2 lane %0d", n), exp_rs2[n], rs2_phys[n]);
                check_field($sformatf("rd lane %0d", n), exp_rd[n], rd_phys[n]);
                check_field($sformatf("old rd lane %0d", n), exp_old_rd[n], old_rd_phys[n]);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic begin_test(string name);
        test_name       = name;
        test_check_base = checks;
        test_err_base   = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_base) begin
            $display("%-14s passed, %0d checks", test_name, checks - test_check_base);
        end else begin
            tests_failed++;
            $display("%-14s %0d errors in %0d checks", test_name, errors - test_err_base,
                     checks - test_check_base);
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_lanes(logic [RENAME_WIDTH-1:0] valid, int reg_bits);
        decode_valid = valid;
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            rs1_arch[n] = rand_bits(reg_bits);
            rs2_arch[n] = rand_bits(reg_bits);
            rd_arch[n]  = rand_bits(reg_bits);
            rd_we[n]    = lfsr_bit();
        end
    endtask

    // Retire up to k of the oldest outstanding slots
    task automatic commit_oldest(int k);
        commit_valid = '0;
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            if (n < k && n < pend_idx.size()) begin
                commit_valid[n]   = 1'b1;
                commit_arch[n]    = pend_arch[n];
                commit_rob_idx[n] = pend_idx[n];
            end
        end
    endtask

    task automatic random_cycle(int reg_bits);
        fill_lanes(3'(rand_bits(3)), reg_bits);
        commit_oldest(rand_bits(2));
        step();
    endtask

    initial begin
        decode_valid = '0;
        rd_we        = '0;
        commit_valid = '0;
        flush_i      = 1'b0;
        for (int n = 0; n < RENAME_WIDTH; n++) begin
            rs1_arch[n]       = '0;
            rs2_arch[n]       = '0;
            rd_arch[n]        = '0;
            commit_arch[n]    = '0;
            commit_rob_idx[n] = '0;
        end

        // Identity reads of every register without writes
        begin_test("reset_state");
        // Valid lanes offered during reset must not be accepted
        decode_valid = 3'b111;
        repeat (RESET_CYCLES / 2) @(posedge clk);
        #1;
        check_field("ready in reset", 6'(3'b111), 6'(rename_ready_o));
        check_field("valid in reset", 6'(0), 6'(rename_valid_o));
        @(posedge reset);
        for (int c = 0; c < LEN_RESET; c++) begin
            decode_valid = 3'b111;
            rd_we        = '0;
            for (int n = 0; n < RENAME_WIDTH; n++) begin
                rs1_arch[n] = arch_addr_t'(6 * c + 2 * n);
                rs2_arch[n] = arch_addr_t'(6 * c + 2 * n + 1);
                rd_arch[n]  = '0;
            end
            commit_oldest(0);
            step();
        end
        end_test();

        // Long enough for the head to wrap
        begin_test("tag_sequence");
        repeat (LEN_TAGS) random_cycle(5);
        end_test();

        // Registers 0 to 3 including x0 so lanes collide often
        begin_test("group_bypass");
        repeat (LEN_BYPASS) begin
            fill_lanes(3'b111, 2);
            commit_oldest(3);
            step();
        end
        end_test();

        begin_test("commit_release");
        repeat (LEN_COMMIT) begin
            fill_lanes(3'(rand_bits(3)), 3);
            commit_oldest(3);
            step();
        end
        end_test();

        // Drain the free list, hold, then refill through commits
        begin_test("ready_exhaust");
        while (rename_ready_o != '0) begin
            fill_lanes(3'b111, 5);
            commit_oldest(0);
            step();
        end
        repeat (2) begin
            fill_lanes(3'b111, 5);
            commit_oldest(0);
            step();
        end
        while (rename_ready_o != 3'b111) begin
            fill_lanes(3'b111, 5);
            commit_oldest(3);
            step();
        end
        end_test();

        begin_test("flush");
        repeat (10) random_cycle(5);
        fill_lanes(3'(rand_bits(3)), 5);
        commit_oldest(rand_bits(2));
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        repeat (LEN_FLUSH - 11) random_cycle(5);
        end_test();

        decode_valid = '0;
        commit_valid = '0;
        step();
        $display("Tests run %0d, passed %0d, failed %0d; checks %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/rename_pkg.sv
verilog/rob_tag_free_list.sv
verilog/map_table.sv
verilog/rename_merge.sv
verilog/register_rename.sv
test/rename_clock_gen.sv
test/register_rename_tb.sv

//--- Makefile
# Verilator build and run of the rename testbench

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vregister_rename_tb: verilog.f $(wildcard verilog/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing -Wno-fatal --top-module register_rename_tb \
		-f verilog.f -o Vregister_rename_tb

# Pass only when the log holds the pass message
run: obj_dir/Vregister_rename_tb
	./obj_dir/Vregister_rename_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
